/* pipe_trace_pkg.sv */
// Shared widths, opcodes and instruction views; stall counts saturate at 15, RV32-style encoding assumed
package pipe_trace_pkg;

    //////////////////////////////
    // Pipeline widths
    //////////////////////////////
    localparam int pc_w        = 32;  // One 32-bit word
    localparam int instr_w     = 32;  // Fixed-length instruction word
    localparam int stall_cnt_w = 4;   // Per-instruction stall counter

    // Formats that write no destination register
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////
    // Register-writing layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;      // Bits 11:7
        logic [6:0] opcode;
    } rd_fmt_t;

    // Store / branch layout, same opcode position
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;  // Same bits as rd
        logic [6:0] opcode;
    } sb_fmt_t;

    // One word, two decodes
    typedef union packed {
        rd_fmt_t rd_view;
        sb_fmt_t sb_view;
    } instr_word_u;

    // Saturating stall counter step, holds at all ones
    function automatic logic [stall_cnt_w-1:0] sat_inc(input logic [stall_cnt_w-1:0] cnt);
        return (&cnt) ? cnt : cnt + 1'b1;
    endfunction

endpackage

/* trace_capture.sv */
// Fetch stage of the trace unit; accepts only with stall and flush low, tag wraps at 2^TAG_W
`timescale 1ns/1ps

module trace_capture #(
    parameter int TAG_W = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   fetch_valid,
    input  logic                                   stall,
    input  logic                                   flush,
    input  logic [pipe_trace_pkg::pc_w-1:0]        fetch_pc,
    input  logic [pipe_trace_pkg::instr_w-1:0]     fetch_instr,
    output logic                                   f_valid,
    output logic [TAG_W-1:0]                       f_tag,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] f_stalls,
    output logic                                   wr_en,
    output logic [TAG_W-1:0]                       wr_tag,
    output logic [pipe_trace_pkg::pc_w-1:0]        wr_pc,
    output logic [pipe_trace_pkg::instr_w-1:0]     wr_instr
);
    import pipe_trace_pkg::*;

    logic             accept;   // Fetch taken this edge
    logic [TAG_W-1:0] tag_cnt;  // Next tag to hand out

    assign accept = fetch_valid & ~stall & ~flush;  // Flush wins over everything

    // Table write happens on the acceptance edge itself
    assign wr_en    = accept;
    assign wr_tag   = tag_cnt;
    assign wr_pc    = fetch_pc;
    assign wr_instr = fetch_instr;

    //////////////////////////////
    // Fetch valid and tag counter
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid <= 1'b0;
            tag_cnt <= '0;
        end else begin
            if (flush)
                f_valid <= 1'b0;         // Wrong-path fetch dropped
            else if (!stall)
                f_valid <= fetch_valid;  // Same condition as accept here
            if (accept)
                tag_cnt <= tag_cnt + 1'b1;  // Wraps, never reused while in flight
        end
    end

    // Tag and stall count of the held instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            f_tag    <= tag_cnt;
            f_stalls <= '0;
        end else if (stall && f_valid) begin
            f_stalls <= sat_inc(f_stalls);  // Held in fetch one more cycle
        end
    end

endmodule

/* stage_tracker.sv */
// Decode, execute and memory tag pipeline; decode holds under stall, flush clears decode and wins
`timescale 1ns/1ps

module stage_tracker #(
    parameter int TAG_W = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   stall,
    input  logic                                   flush,
    input  logic                                   f_valid,
    input  logic [TAG_W-1:0]                       f_tag,
    input  logic [pipe_trace_pkg::stall_cnt_w-1:0] f_stalls,
    output logic [TAG_W-1:0]                       rd_tag,
    output logic                                   m_valid,
    output logic [TAG_W-1:0]                       m_tag,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] m_stalls
);
    import pipe_trace_pkg::*;

    // Decode stage
    logic                   d_valid;
    logic [TAG_W-1:0]       d_tag;
    logic [stall_cnt_w-1:0] d_stalls;

    // Execute stage
    logic                   e_valid;
    logic [TAG_W-1:0]       e_tag;
    logic [stall_cnt_w-1:0] e_stalls;

    //////////////////////////////
    // Valid bits
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            // Decode: cleared by flush, held by stall
            if (flush)
                d_valid <= 1'b0;
            else if (!stall)
                d_valid <= f_valid;

            // Bubble into execute on stall, nothing from decode on flush
            e_valid <= d_valid & ~stall & ~flush;

            m_valid <= e_valid;  // Execute and memory never wait
        end
    end

    //////////////////////////////
    // Tags and stall counts
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!stall) begin
            d_tag    <= f_tag;
            d_stalls <= f_stalls;   // Carry the fetch-stage count along
        end else if (d_valid) begin
            d_stalls <= sat_inc(d_stalls);  // Held in decode one more cycle
        end
    end

    // Later stages just shift, payload of a bubble is don't-care
    always_ff @(posedge clk) begin
        e_tag    <= d_tag;
        e_stalls <= d_stalls;
        m_tag    <= e_tag;
        m_stalls <= e_stalls;
    end

    // Table read for the instruction entering write-back
    assign rd_tag = m_tag;

endmodule

/* trace_table.sv */
// Tag-indexed pc and instruction store, 2^TAG_W entries, no reset, async read, read of an unwritten tag is X
`timescale 1ns/1ps

module trace_table #(
    parameter int TAG_W = 4
) (
    input  logic                               clk,
    input  logic                               wr_en,
    input  logic [TAG_W-1:0]                   wr_tag,
    input  logic [pipe_trace_pkg::pc_w-1:0]    wr_pc,
    input  logic [pipe_trace_pkg::instr_w-1:0] wr_instr,
    input  logic [TAG_W-1:0]                   rd_tag,
    output logic [pipe_trace_pkg::pc_w-1:0]    rd_pc,
    output pipe_trace_pkg::instr_word_u        rd_instr
);
    import pipe_trace_pkg::*;

    localparam int DEPTH = 1 << TAG_W;  // One entry per tag value

    //////////////////////////////
    // Storage
    //////////////////////////////
    logic [pc_w-1:0]    pc_mem    [DEPTH];
    logic [instr_w-1:0] instr_mem [DEPTH];

    // Written once per accepted fetch
    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_tag]    <= wr_pc;
            instr_mem[wr_tag] <= wr_instr;
        end
    end

    // Zero-latency read
    // Entry stays stable until the tag wraps around, far after retire
    assign rd_pc    = pc_mem[rd_tag];
    assign rd_instr = instr_mem[rd_tag];  // Raw word, decoded downstream

endmodule

/* retire_formatter.sv */
// Write-back stage; one-cycle retire pulse, no back-pressure, retired_count wraps at 2^32
`timescale 1ns/1ps

module retire_formatter #(
    parameter int TAG_W = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   m_valid,
    input  logic [TAG_W-1:0]                       m_tag,
    input  logic [pipe_trace_pkg::stall_cnt_w-1:0] m_stalls,
    input  logic [pipe_trace_pkg::pc_w-1:0]        rd_pc,
    input  pipe_trace_pkg::instr_word_u            rd_instr,
    output logic                                   retire_valid,
    output logic [TAG_W-1:0]                       retire_tag,
    output logic [pipe_trace_pkg::pc_w-1:0]        retire_pc,
    output logic [4:0]                             retire_rd,
    output logic                                   retire_writes,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls,
    output logic [31:0]                            retired_count
);
    import pipe_trace_pkg::*;

    logic       is_sb;   // Store or branch format
    logic       writes;  // Instruction updates a register
    logic [4:0] rd_sel;  // Reported destination

    //////////////////////////////
    // Instruction decode
    //////////////////////////////
    // Opcode sits in the same place in both views, checked through sb_view
    assign is_sb = (rd_instr.sb_view.opcode == op_store) ||
                   (rd_instr.sb_view.opcode == op_branch);

    // x0 as destination counts as no write
    assign writes = !is_sb && (rd_instr.rd_view.rd != 5'd0);

    // Bits 11:7 are imm_lo for store/branch, so masked off
    assign rd_sel = writes ? rd_instr.rd_view.rd : 5'd0;

    //////////////////////////////
    // Write-back register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            retire_valid <= m_valid;          // One pulse per instruction
            if (m_valid)
                retired_count <= retired_count + 32'd1;  // Counts with the pulse
        end
    end

    // Retire record fields, meaningful only with retire_valid
    always_ff @(posedge clk) begin
        retire_tag    <= m_tag;
        retire_pc     <= rd_pc;
        retire_rd     <= rd_sel;
        retire_writes <= writes;
        retire_stalls <= m_stalls;
    end

endmodule

/* pipe_trace_top.sv */
// Trace unit top; TAG_W of 3 or more, stall and flush must follow the watched CPU exactly
`timescale 1ns/1ps

module pipe_trace_top #(
    parameter int TAG_W = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   fetch_valid,
    input  logic [pipe_trace_pkg::pc_w-1:0]        fetch_pc,
    input  logic [pipe_trace_pkg::instr_w-1:0]     fetch_instr,
    input  logic                                   stall,
    input  logic                                   flush,
    output logic                                   retire_valid,
    output logic [TAG_W-1:0]                       retire_tag,
    output logic [pipe_trace_pkg::pc_w-1:0]        retire_pc,
    output logic [4:0]                             retire_rd,
    output logic                                   retire_writes,
    output logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls,
    output logic [31:0]                            retired_count
);
    import pipe_trace_pkg::*;

    // Fetch stage outputs
    logic                   f_valid;
    logic [TAG_W-1:0]       f_tag;
    logic [stall_cnt_w-1:0] f_stalls;

    // Table write port
    logic                   wr_en;
    logic [TAG_W-1:0]       wr_tag;
    logic [pc_w-1:0]        wr_pc;
    logic [instr_w-1:0]     wr_instr;

    // Memory stage and table read port
    logic                   m_valid;
    logic [TAG_W-1:0]       m_tag;
    logic [stall_cnt_w-1:0] m_stalls;
    logic [TAG_W-1:0]       rd_tag;
    logic [pc_w-1:0]        rd_pc;
    instr_word_u            rd_instr;

    //////////////////////////////
    // Input side
    //////////////////////////////
    trace_capture #(.TAG_W(TAG_W)) u_capture (
        .clk, .rst, .fetch_valid, .stall, .flush, .fetch_pc, .fetch_instr,
        .f_valid, .f_tag, .f_stalls, .wr_en, .wr_tag, .wr_pc, .wr_instr
    );

    //////////////////////////////
    // Tracking and storage
    //////////////////////////////
    stage_tracker #(.TAG_W(TAG_W)) u_tracker (
        .clk, .rst, .stall, .flush, .f_valid, .f_tag, .f_stalls,
        .rd_tag, .m_valid, .m_tag, .m_stalls
    );

    trace_table #(.TAG_W(TAG_W)) u_table (
        .clk, .wr_en, .wr_tag, .wr_pc, .wr_instr, .rd_tag, .rd_pc, .rd_instr
    );

    //////////////////////////////
    // Output side
    //////////////////////////////
    retire_formatter #(.TAG_W(TAG_W)) u_formatter (
        .clk, .rst, .m_valid, .m_tag, .m_stalls, .rd_pc, .rd_instr,
        .retire_valid, .retire_tag, .retire_pc, .retire_rd, .retire_writes,
        .retire_stalls, .retired_count
    );

endmodule

/* pipe_trace_sva.sv */
// Bound checks on the trace top; idle while rst is high, TAG_W taken from the bound instance
`timescale 1ns/1ps

module pipe_trace_sva #(
    parameter int TAG_W = 4
) (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic             flush,
    input logic             f_valid,
    input logic [TAG_W-1:0] wr_tag,
    input logic             retire_valid,
    input logic [TAG_W-1:0] retire_tag,
    input logic [31:0]      retired_count
);

    int fail_cnt = 0;  // Assertion failures so far

    // One pulse per instruction
    a_single_pulse: assert property (@(posedge clk) disable iff (rst)
        retire_valid && $past(retire_valid) |-> retire_tag != $past(retire_tag))
    else begin
        $error("retire_valid high two cycles for tag %0d", retire_tag);
        fail_cnt++;
    end

    // Tag counter frozen and no new fetch valid while stall or flush is high
    a_no_accept: assert property (@(posedge clk) disable iff (rst)
        (stall || flush) |=> $stable(wr_tag) && (!f_valid || $past(f_valid)))
    else begin
        $error("Fetch accepted with stall or flush high");
        fail_cnt++;
    end

    // Counter follows the pulse
    a_count_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> retired_count == $past(retired_count) + 32'(retire_valid))
    else begin
        $error("retired_count step does not match retire_valid");
        fail_cnt++;
    end

endmodule

bind pipe_trace_top pipe_trace_sva #(.TAG_W(TAG_W)) u_sva (
    .clk, .rst, .stall, .flush, .f_valid, .wr_tag, .retire_valid, .retire_tag, .retired_count
);

/* pipe_trace_checker.sv */
// Retire record checker; compares at the falling edge, records past the expected list are only counted
`timescale 1ns/1ps

module pipe_trace_checker #(
    parameter int TAG_W = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   retire_valid,
    input  logic [TAG_W-1:0]                       retire_tag,
    input  logic [pipe_trace_pkg::pc_w-1:0]        retire_pc,
    input  logic [4:0]                             retire_rd,
    input  logic                                   retire_writes,
    input  logic [pipe_trace_pkg::stall_cnt_w-1:0] retire_stalls,
    input  logic [31:0]                            retired_count,
    input  int                                     n_exp,
    input  logic [TAG_W-1:0]                       exp_tag,
    input  logic [pipe_trace_pkg::pc_w-1:0]        exp_pc,
    input  logic [4:0]                             exp_rd,
    input  logic                                   exp_writes,
    input  logic [pipe_trace_pkg::stall_cnt_w-1:0] exp_stalls,
    input  int                                     exp_cycle,
    output int                                     n_seen,
    output int                                     n_pass,
    output int                                     n_fail
);

    int cyc;  // Rising edges since reset release

    always @(posedge clk) begin
        if (rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // Prints one [FAIL] line on a mismatch
    function automatic bit field_differs(input string name, input logic [31:0] got,
                                         input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    //////////////////////////////
    // Record compare
    //////////////////////////////
    always @(negedge clk) begin : compare
        bit bad;
        if (rst) begin
            n_seen = 0;
            n_pass = 0;
            n_fail = 0;
        end else if (retire_valid) begin
            if (n_seen < n_exp) begin
                bad = 1'b0;
                bad |= field_differs("retire_tag", retire_tag, exp_tag);
                bad |= field_differs("retire_pc", retire_pc, exp_pc);
                bad |= field_differs("retire_rd", retire_rd, exp_rd);
                bad |= field_differs("retire_writes", retire_writes, exp_writes);
                bad |= field_differs("retire_stalls", retire_stalls, exp_stalls);
                bad |= field_differs("retire_valid cycle", cyc, exp_cycle);  // Timing rule
                bad |= field_differs("retired_count", retired_count, n_seen + 1);
                if (bad) begin
                    n_fail++;
                    $display("Record %0d (tag %0d): mismatch", n_seen, exp_tag);
                end else begin
                    n_pass++;
                    $display("Record %0d (tag %0d, pc 0x%h): ok", n_seen, exp_tag, exp_pc);
                end
            end
            n_seen++;  // Surplus ones too
        end
    end

endmodule

/* pipe_trace_tb.sv */
// Trace unit testbench; patterns file read from the project root, expected tags assume TAG_W of 4
`timescale 1ns/1ps

module pipe_trace_tb;
    import pipe_trace_pkg::*;

    localparam int TAG_W    = 4;
    localparam int EXP_BASE = 'h100;  // First word of the expected block

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   fetch_valid;
    logic                   stall;
    logic                   flush;
    logic [pc_w-1:0]        fetch_pc;
    logic [instr_w-1:0]     fetch_instr;

    // DUT outputs
    logic                   retire_valid;
    logic [TAG_W-1:0]       retire_tag;
    logic [pc_w-1:0]        retire_pc;
    logic [4:0]             retire_rd;
    logic                   retire_writes;
    logic [stall_cnt_w-1:0] retire_stalls;
    logic [31:0]            retired_count;

    logic [31:0]      pat [512];               // Header, stimulus rows, expected records
    int               accept_at [1 << TAG_W];  // Cycle count right after each tag's acceptance
    logic [TAG_W-1:0] tag_model;               // Next tag by the acceptance rule
    int               n_rows;
    int               n_exp;
    int               n_err;                   // Failures outside the record compare
    int               n_seen;
    int               n_pass;
    int               n_fail;

    // Expected record for the next retirement
    logic [TAG_W-1:0]       exp_tag;
    logic [pc_w-1:0]        exp_pc;
    logic [4:0]             exp_rd;
    logic                   exp_writes;
    logic [stall_cnt_w-1:0] exp_stalls;
    int                     exp_cycle;

    assign exp_tag    = pat[EXP_BASE + 5 * n_seen][TAG_W-1:0];
    assign exp_pc     = pat[EXP_BASE + 5 * n_seen + 1];
    assign exp_rd     = pat[EXP_BASE + 5 * n_seen + 2][4:0];
    assign exp_writes = pat[EXP_BASE + 5 * n_seen + 3][0];
    assign exp_stalls = pat[EXP_BASE + 5 * n_seen + 4][stall_cnt_w-1:0];
    assign exp_cycle  = accept_at[exp_tag] + 4 + exp_stalls;  // Four edges plus one per stall

    always #4 clk = ~clk;  // 8 ns period

    pipe_trace_top #(.TAG_W(TAG_W)) u_dut (
        .clk, .rst, .fetch_valid, .fetch_pc, .fetch_instr, .stall, .flush,
        .retire_valid, .retire_tag, .retire_pc, .retire_rd, .retire_writes,
        .retire_stalls, .retired_count
    );

    pipe_trace_checker #(.TAG_W(TAG_W)) u_checker (
        .clk, .rst, .retire_valid, .retire_tag, .retire_pc, .retire_rd, .retire_writes,
        .retire_stalls, .retired_count, .n_exp, .exp_tag, .exp_pc, .exp_rd, .exp_writes,
        .exp_stalls, .exp_cycle, .n_seen, .n_pass, .n_fail
    );

    // One pattern row onto the inputs, and the tag it should get
    task automatic drive_row(input int c);
        logic [31:0] ctrl;
        ctrl = pat[2 + 3 * c];      // fetch_valid bit 8, stall bit 4, flush bit 0
        fetch_valid <= ctrl[8];
        stall       <= ctrl[4];
        flush       <= ctrl[0];
        fetch_pc    <= pat[3 + 3 * c];
        fetch_instr <= pat[4 + 3 * c];
        if (ctrl[8] && !ctrl[4] && !ctrl[0]) begin
            accept_at[tag_model] = c + 1;
            tag_model = tag_model + 1'b1;  // Wraps like the DUT counter
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        fetch_pc    = '0;
        fetch_instr = '0;
        tag_model   = '0;
        n_err       = 0;
        foreach (accept_at[i])
            accept_at[i] = 0;
        $readmemh("pipe_trace_patterns.mem", pat);
        n_rows = pat[0];
        n_exp  = pat[1];
        repeat (3) @(posedge clk);  // Reset over three edges
        rst <= 1'b0;
        for (int c = 0; c < n_rows; c++) begin
            drive_row(c);
            @(posedge clk);
        end
        fetch_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        // Pipeline tail, then room for a surplus record
        for (int w = 0; w < 8 && n_seen < n_exp; w++)
            @(posedge clk);
        repeat (5) @(posedge clk);
        if (n_seen < n_exp) begin
            $display("Missing retirements: only %0d of %0d records came out", n_seen, n_exp);
            n_err++;
        end
        if (n_seen > n_exp) begin
            $display("Surplus retirements: %0d records came out, %0d expected", n_seen, n_exp);
            n_err++;
        end
        if (retired_count !== n_exp) begin
            $display("[FAIL] t=%0t retired_count: got %0d, expected %0d",
                     $time, retired_count, n_exp);
            n_err++;
        end
        if (u_dut.u_sva.fail_cnt != 0) begin
            $display("Assertions fired %0d times", u_dut.u_sva.fail_cnt);
            n_err++;
        end
        $display("Records expected %0d, retired %0d, passed %0d, failed %0d, other errors %0d",
                 n_exp, n_seen, n_pass, n_fail, n_err);
        if (n_fail == 0 && n_err == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog, pattern length plus a fixed tail
    initial begin : watchdog
        @(negedge rst);
        repeat (n_rows + 20) @(posedge clk);
        $display("Timeout: run still busy %0d cycles after reset release", n_rows + 20);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* pipe_trace_patterns.mem */
// Word 0 rows, word 1 records; then per row: ctrl (fetch_valid<<8|stall<<4|flush), pc, instr
// From @100 one expected retire record per line: tag pc rd writes stalls
18 12
100 00000100 00100093
100 00000104 00508113
100 00000108 0020A423
100 0000010C 00208363
100 00000110 002082B3
100 00000114 00000013
100 00000118 00130313
100 0000011C 00612623
110 00000120 00B31463
110 00000120 00B31463
100 00000120 00B31463
100 00000124 00148493
100 00000128 00150513
101 0000012C 00158593
100 00000200 123455B7
100 00000204 00308013
100 00000208 008000EF
100 0000020C 00208FB3
100 00000210 00008023
100 00000214 00170713
100 00000218 0040A783
100 0000021C 00E7CFE3
110 00000220 00180813
100 00000220 00180813
@100
0 00000100 01 1 0
1 00000104 02 1 0
2 00000108 00 0 0
3 0000010C 00 0 0
4 00000110 05 1 0
5 00000114 00 0 0
6 00000118 06 1 2
7 0000011C 00 0 2
8 00000120 00 0 0
B 00000200 0B 1 0
C 00000204 00 0 0
D 00000208 01 1 0
E 0000020C 1F 1 0
F 00000210 00 0 0
0 00000214 0E 1 0
1 00000218 0F 1 1
2 0000021C 00 0 1
3 00000220 10 1 0

/* pipe_trace.f */
pipe_trace_pkg.sv
trace_capture.sv
stage_tracker.sv
trace_table.sv
retire_formatter.sv
pipe_trace_top.sv
pipe_trace_sva.sv
pipe_trace_checker.sv
pipe_trace_tb.sv
